// File: miniCore.f
+incdir+verilog
verilog/miniCorePkg.sv
verilog/miniCoreDecoder.sv
verilog/miniCoreController.sv
verilog/miniCoreRegFile.sv
verilog/miniCoreAlu.sv
verilog/miniCoreSequencer.sv
verilog/miniCore.sv
verification/miniCoreTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the miniCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f miniCore.f --top-module miniCoreTb -o miniCoreSim

./obj_dir/miniCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    exit 0
else
    echo "simulation did not report success"
    exit 1
fi

// File: verification/miniCoreTb.sv
`timescale 1ns/1ps
`include "miniCore_params.svh"

module miniCoreTb;

    localparam int ClockPeriod   = 20;
    localparam int ResetCycles   = 8;
    localparam int MemWords      = 256;     // 1 KB word array indexed by bits [9:2]
    localparam int TestCount     = 6;
    localparam int CyclesPerTest = 500;     // Longest program 27 instr of up to 11 cycles
    localparam int DataBase      = 32'h200; // Operands preloaded here
    localparam int CopyBase      = 32'h280; // First copy in the round trip
    localparam int OutBase       = 32'h300; // Results and markers
    localparam int OpImm         = 32'h13;
    localparam int OpLoad        = 32'h03;
    localparam int Ecall         = 32'h73;

    logic                  clock  = 1'b0;
    logic                  reset  = 1'b1;
    logic                  wbAck  = 1'b0;
    miniCorePkg::tWord     wbDatR = '0;
    miniCorePkg::tWbMaster wbOut;
    logic                  halted;

    logic [31:0] image [MemWords];    // Program and data copied in during reset
    logic [31:0] mem   [MemWords];    // Live memory seen by the bus
    logic [31:0] waitSeed  = 32'h95;  // Wait-state generator
    logic [31:0] stimSeed  = 32'h95;  // Operand generator
    logic [1:0]  waitLeft  = 2'd0;
    logic        busy      = 1'b0;    // Access accepted and counting wait states
    int          progAddr  = 0;
    int          failCount = 0;

    miniCore dut0 (
        .Clock  (clock),
        .Reset  (reset),
        .WbOut  (wbOut),
        .WbAck  (wbAck),
        .WbDatR (wbDatR),
        .Halted (halted)
    );

    always #(ClockPeriod / 2) clock = ~clock;

    // Wishbone classic slave with 0 to 3 wait states per access
    always @(negedge clock) begin
        if (reset) begin
            mem   = image;
            wbAck = 1'b0;
            busy  = 1'b0;
        end else if (wbAck) begin
            wbAck = 1'b0; // Ack lasts one cycle
        end else if (wbOut.Cyc && wbOut.Stb) begin
            checkValue("WbOut.Adr[1:0]", 32'(wbOut.Adr[1:0]), 32'd0); // Word accesses only
            if (!busy) begin
                busy     = 1'b1;
                waitSeed = lcgNext(waitSeed);
                waitLeft = waitSeed[17:16];
            end
            if (waitLeft == 2'd0) begin
                wbAck = 1'b1;
                busy  = 1'b0;
                if (wbOut.We) begin
                    mem[wbOut.Adr[9:2]] = wbOut.DatW;
                end else begin
                    wbDatR = mem[wbOut.Adr[9:2]];
                end
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] wordIndex(input int addr);
        return addr[9:2];
    endfunction

    function automatic logic [31:0] fillWord(input int addr);
        return {16'hC0DE, addr[15:0]}; // Unwritten words carry their own address
    endfunction

    function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                         input int rd, input int opcode);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23}; // SW
    endfunction

    function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1,
                                         input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    // RV32I result by funct3
    function automatic logic [31:0] arithRef(input int f3, input logic isSub,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            0:       return isSub ? a - b : a + b;
            7:       return a & b;
            6:       return a | b;
            4:       return a ^ b;
            default: return 32'($signed(a) < $signed(b)); // SLT and SLTI compare signed
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failCount++;
            $display("mismatch %s: got %08h, expected %08h", name, actual, expected);
            $display("test failed");
            $fatal(1, "check on %s", name);
        end
    endtask

    task automatic checkMem(input int addr, input logic [31:0] expected);
        checkValue($sformatf("mem[%08h]", addr), mem[wordIndex(addr)], expected);
    endtask

    task automatic clearImage();
        for (int i = 0; i < MemWords; i++) begin
            image[wordIndex(4 * i)] = fillWord(4 * i);
        end
        progAddr = 0;
    endtask

    task automatic emit(input logic [31:0] instr);
        image[wordIndex(progAddr)] = instr;
        progAddr += 4;
    endtask

    // Bus idle and not halted all through reset
    task automatic pulseReset();
        @(negedge clock);
        reset = 1'b1;
        repeat (ResetCycles) begin
            @(negedge clock);
            checkValue("WbOut.Cyc", 32'(wbOut.Cyc), 32'd0);
            checkValue("WbOut.Stb", 32'(wbOut.Stb), 32'd0);
            checkValue("WbOut.We", 32'(wbOut.We), 32'd0);
            checkValue("Halted", 32'(halted), 32'd0);
        end
        reset = 1'b0;
    endtask

    task automatic waitHalt();
        while (!halted) begin
            @(negedge clock);
        end
    endtask

    task automatic resetTest();
        clearImage();
        emit(Ecall);
        pulseReset();
        @(negedge clock); // First fetch opens right after reset
        checkValue("WbOut.Cyc", 32'(wbOut.Cyc), 32'd1);
        checkValue("WbOut.Stb", 32'(wbOut.Stb), 32'd1);
        checkValue("WbOut.We", 32'(wbOut.We), 32'd0);
        checkValue("WbOut.Adr", wbOut.Adr, `MINI_CORE_RESET_PC);
        waitHalt();
    endtask

    task automatic arithTest();
        int          rF3 [6] = '{0, 0, 7, 6, 4, 2};  // ADD SUB AND OR XOR SLT
        int          rF7 [6] = '{0, 32, 0, 0, 0, 0};
        int          iF3 [5] = '{0, 7, 6, 4, 2};     // ADDI ANDI ORI XORI SLTI
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] immExt;
        logic [31:0] expected [$];
        clearImage();
        stimSeed = lcgNext(stimSeed);
        opA      = stimSeed | 32'h8000_0000; // Negative so SLT sees the sign
        stimSeed = lcgNext(stimSeed);
        opB      = stimSeed & 32'h7FFF_FFFF; // Non-negative
        image[wordIndex(DataBase)]     = opA;
        image[wordIndex(DataBase + 4)] = opB;
        emit(encI(DataBase, 0, 2, 1, OpLoad));     // x1 = opA
        emit(encI(DataBase + 4, 0, 2, 2, OpLoad)); // x2 = opB
        for (int k = 0; k < 6; k++) begin
            emit(encR(rF7[k], 2, 1, rF3[k], 3));
            emit(encS(OutBase + 4 * k, 3, 0));
            expected.push_back(arithRef(rF3[k], rF7[k] != 0, opA, opB));
        end
        emit(encR(0, 1, 2, 2, 3)); // SLT with operands swapped
        emit(encS(OutBase + 24, 3, 0));
        expected.push_back(arithRef(2, 1'b0, opB, opA));
        for (int k = 0; k < 5; k++) begin
            stimSeed = lcgNext(stimSeed);
            immExt   = {{20{stimSeed[27]}}, stimSeed[27:16]};
            emit(encI(int'(immExt), 1, iF3[k], 3, OpImm));
            emit(encS(OutBase + 28 + 4 * k, 3, 0));
            expected.push_back(arithRef(iF3[k], 1'b0, opA, immExt));
        end
        emit(Ecall);
        pulseReset();
        waitHalt();
        foreach (expected[k]) begin
            checkMem(OutBase + 4 * k, expected[k]);
        end
    endtask

    task automatic loadStoreTest();
        logic [31:0] orig [4];
        clearImage();
        for (int k = 0; k < 4; k++) begin
            stimSeed = lcgNext(stimSeed);
            orig[k]  = stimSeed;
            image[wordIndex(DataBase + 4 * k)] = orig[k];
        end
        for (int k = 0; k < 4; k++) begin
            emit(encI(DataBase + 4 * k, 0, 2, 5 + k, OpLoad)); // x5..x8
        end
        for (int k = 0; k < 4; k++) begin
            emit(encS(CopyBase + 4 * k, 5 + k, 0));
        end
        for (int k = 0; k < 4; k++) begin
            emit(encI(CopyBase + 4 * k, 0, 2, 9 + k, OpLoad)); // x9..x12
        end
        for (int k = 0; k < 4; k++) begin
            emit(encS(OutBase + 4 * k, 9 + k, 0));
        end
        emit(Ecall);
        pulseReset();
        waitHalt();
        for (int k = 0; k < 4; k++) begin
            checkMem(CopyBase + 4 * k, orig[k]);
            checkMem(OutBase + 4 * k, orig[k]);
        end
    endtask

    // Slot right after a branch is skipped only when the branch is taken
    task automatic checkSlot(input int addr, input logic taken);
        checkMem(addr, taken ? fillWord(addr) : 32'd1);
    endtask

    task automatic branchTest();
        int x1v = 5;
        int x2v = 5;
        int x3v = 7;
        clearImage();
        emit(encI(x1v, 0, 0, 1, OpImm));
        emit(encI(x2v, 0, 0, 2, OpImm));
        emit(encI(x3v, 0, 0, 3, OpImm));
        emit(encI(1, 0, 0, 4, OpImm));          // x4 = marker
        emit(encB(8, 2, 1, 0));                 // BEQ equal
        emit(encS(OutBase, 4, 0));
        emit(encS(OutBase + 4, 4, 0));          // Target
        emit(encB(8, 3, 1, 0));                 // BEQ not equal
        emit(encS(OutBase + 8, 4, 0));
        emit(encS(OutBase + 12, 4, 0));
        emit(encB(8, 3, 1, 1));                 // BNE not equal
        emit(encS(OutBase + 16, 4, 0));
        emit(encS(OutBase + 20, 4, 0));
        emit(encB(8, 2, 1, 1));                 // BNE equal
        emit(encS(OutBase + 24, 4, 0));
        emit(encS(OutBase + 28, 4, 0));
        emit(Ecall);
        pulseReset();
        waitHalt();
        checkSlot(OutBase, x1v == x2v);
        checkSlot(OutBase + 8, x1v == x3v);
        checkSlot(OutBase + 16, x1v != x3v);
        checkSlot(OutBase + 24, x1v != x2v);
        for (int k = 0; k < 4; k++) begin
            checkMem(OutBase + 4 + 8 * k, 32'd1); // Every target reached
        end
    endtask

    task automatic jumpTest();
        int jalAddr;
        int jalrAddr;
        clearImage();
        emit(encI(1, 0, 0, 4, OpImm));          // x4 = marker
        jalAddr = progAddr;
        emit(encJ(12, 1));                      // JAL x1 to jalAddr + 12
        emit(encS(OutBase, 4, 0));
        emit(encS(OutBase + 4, 4, 0));
        emit(encS(OutBase + 8, 1, 0));          // Link of JAL
        emit(encI(33, 0, 0, 5, OpImm));
        jalrAddr = progAddr;
        emit(encI(4, 5, 0, 2, 32'h67));         // JALR x2 to 4(x5) where 37 rounds down to 36
        emit(encS(OutBase + 12, 4, 0));
        emit(encS(OutBase + 16, 4, 0));
        emit(encS(OutBase + 20, 2, 0));         // Address 36 stores the JALR link
        emit(encS(OutBase + 24, 4, 0));
        emit(Ecall);
        pulseReset();
        waitHalt();
        checkMem(OutBase, fillWord(OutBase));
        checkMem(OutBase + 4, fillWord(OutBase + 4));
        checkMem(OutBase + 8, 32'(jalAddr + 4));
        checkMem(OutBase + 12, fillWord(OutBase + 12));
        checkMem(OutBase + 16, fillWord(OutBase + 16));
        checkMem(OutBase + 20, 32'(jalrAddr + 4));
        checkMem(OutBase + 24, 32'd1);
    endtask

    task automatic zeroHaltTest();
        clearImage();
        image[wordIndex(DataBase)] = 32'hDEAD_BEEF;
        emit(encI(123, 0, 0, 0, OpImm));        // ADDI x0
        emit(encS(OutBase, 0, 0));
        emit(encI(55, 0, 0, 1, OpImm));
        emit(encR(0, 1, 1, 0, 0));              // ADD x0, x1, x1
        emit(encS(OutBase + 4, 0, 0));
        emit(encI(DataBase, 0, 2, 0, OpLoad));  // LW x0
        emit(encS(OutBase + 8, 0, 0));
        emit(Ecall);
        pulseReset();
        waitHalt();
        repeat (20) begin
            @(negedge clock);
            checkValue("Halted", 32'(halted), 32'd1);
            checkValue("WbOut.Cyc", 32'(wbOut.Cyc), 32'd0);
        end
        for (int k = 0; k < 3; k++) begin
            checkMem(OutBase + 4 * k, 32'd0);
        end
    endtask

    initial begin
        #(TestCount * CyclesPerTest * ClockPeriod);
        $display("timeout: the core did not halt in the allowed time");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        resetTest();
        arithTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        zeroHaltTest();
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog/miniCore.sv
`timescale 1ns/1ps

module miniCore (
    input  logic                  Clock,
    input  logic                  Reset,
    output miniCorePkg::tWbMaster WbOut,
    input  logic                  WbAck,
    input  miniCorePkg::tWord     WbDatR,
    output logic                  Halted
);

    miniCorePkg::tWord          Instr;
    miniCorePkg::tWord          Pc;
    miniCorePkg::tDecoded       Decoded;
    miniCorePkg::tControllerOut Cntrl;
    miniCorePkg::tWord          Rs1Data;
    miniCorePkg::tWord          Rs2Data;
    miniCorePkg::tWord          AluResult;
    logic                       Taken;
    logic                       DecodeStrobe;
    logic                       RegWrEn;
    miniCorePkg::tWord          RegWrData;

    miniCoreDecoder decoder0 (
        .Instr   (Instr),
        .Decoded (Decoded)
    );

    miniCoreController controller0 (
        .Clock        (Clock),
        .Reset        (Reset),
        .DecodeStrobe (DecodeStrobe),
        .OpType       (Decoded.OpType),
        .CntrlOut     (Cntrl)
    );

    miniCoreRegFile regFile0 (
        .Clock   (Clock),
        .Reset   (Reset),
        .Rs1     (Decoded.Rs1),
        .Rs2     (Decoded.Rs2),
        .Rs1Data (Rs1Data),
        .Rs2Data (Rs2Data),
        .WrEn    (RegWrEn),
        .WrIdx   (Decoded.Rd),  // Instr held until WRITEBACK
        .WrData  (RegWrData)
    );

    miniCoreAlu alu0 (
        .Pc      (Pc),
        .Rs1Data (Rs1Data),
        .Rs2Data (Rs2Data),
        .Decoded (Decoded),
        .Cntrl   (Cntrl),
        .Result  (AluResult),
        .Taken   (Taken)
    );

    miniCoreSequencer sequencer0 (
        .Clock        (Clock),
        .Reset        (Reset),
        .Cntrl        (Cntrl),
        .AluResult    (AluResult),
        .Taken        (Taken),
        .Rs2Data      (Rs2Data),
        .Instr        (Instr),
        .Pc           (Pc),
        .DecodeStrobe (DecodeStrobe),
        .RegWrEn      (RegWrEn),
        .RegWrData    (RegWrData),
        .WbOut        (WbOut),
        .WbAck        (WbAck),
        .WbDatR       (WbDatR),
        .Halted       (Halted)
    );

endmodule

// File: verilog/miniCoreAlu.sv
`timescale 1ns/1ps
`include "miniCore_params.svh"

module miniCoreAlu (
    input  miniCorePkg::tWord          Pc,
    input  miniCorePkg::tWord          Rs1Data,
    input  miniCorePkg::tWord          Rs2Data,
    input  miniCorePkg::tDecoded       Decoded,
    input  miniCorePkg::tControllerOut Cntrl,
    output miniCorePkg::tWord          Result,
    output logic                       Taken
);

    miniCorePkg::tWord OpA;
    miniCorePkg::tWord OpB;
    miniCorePkg::tWord Sum;
    logic              Less;  // Signed compare for SLT
    logic              Equal; // Branch compare on rs1/rs2

    assign OpA   = Cntrl.AluMux1Sel ? Pc : Rs1Data;
    assign OpB   = Cntrl.AluMux2Sel ? Decoded.Imm : Rs2Data;
    assign Sum   = OpA + OpB;
    assign Less  = $signed(OpA) < $signed(OpB);
    assign Equal = (Rs1Data == Rs2Data);

    always_comb begin
        case (Decoded.AluOp)
            miniCorePkg::ALU_SUB: begin
                // Branches carry SUB for the compare but need pc + imm here
                Result = Cntrl.IsBranch ? Sum : OpA - OpB;
            end
            miniCorePkg::ALU_AND: Result = OpA & OpB;
            miniCorePkg::ALU_OR:  Result = OpA | OpB;
            miniCorePkg::ALU_XOR: Result = OpA ^ OpB;
            miniCorePkg::ALU_SLT: Result = {{(`MINI_CORE_XLEN-1){1'b0}}, Less};
            default:              Result = Sum; // ADD, addresses, jump targets
        endcase
    end

    // Jumps always, BEQ on equal, BNE on not equal
    assign Taken = Cntrl.JmpEnable || (Cntrl.IsBranch && (Equal != Decoded.BranchNe));

endmodule

// File: verilog/miniCoreController.sv
`timescale 1ns/1ps
`include "miniCore_params.svh"

module miniCoreController (
    input  logic                       Clock,
    input  logic                       Reset,
    input  logic                       DecodeStrobe,
    input  miniCorePkg::tOpType        OpType,
    output miniCorePkg::tControllerOut CntrlOut
);

    miniCorePkg::tControllerOut CntrlQ101H; // Decode-stage controls

    always_comb begin
        CntrlQ101H          = '0;               // Everything inactive
        CntrlQ101H.WbMuxSel = `MINI_CORE_WB_ALU;
        case (OpType)
            miniCorePkg::I_TYPE: begin
                CntrlQ101H.RegWrEnable = 1'b1;
                CntrlQ101H.AluMux2Sel  = 1'b1; // rs1 + imm
            end
            miniCorePkg::L_TYPE: begin
                CntrlQ101H.RegWrEnable = 1'b1;
                CntrlQ101H.AluMux2Sel  = 1'b1; // Address is rs1 + imm
                CntrlQ101H.MemRdEnable = 1'b1;
                CntrlQ101H.WbMuxSel    = `MINI_CORE_WB_MEM;
            end
            miniCorePkg::R_TYPE: begin
                CntrlQ101H.RegWrEnable = 1'b1; // rs1 op rs2
            end
            miniCorePkg::B_TYPE: begin
                CntrlQ101H.AluMux1Sel = 1'b1; // Target is pc + imm
                CntrlQ101H.AluMux2Sel = 1'b1;
                CntrlQ101H.IsBranch   = 1'b1;
            end
            miniCorePkg::S_TYPE: begin
                CntrlQ101H.AluMux2Sel  = 1'b1;
                CntrlQ101H.MemWrEnable = 1'b1;
            end
            miniCorePkg::J_TYPE: begin
                CntrlQ101H.RegWrEnable = 1'b1;
                CntrlQ101H.AluMux1Sel  = 1'b1; // pc + imm
                CntrlQ101H.AluMux2Sel  = 1'b1;
                CntrlQ101H.JmpEnable   = 1'b1;
                CntrlQ101H.WbMuxSel    = `MINI_CORE_WB_PC4; // Link
            end
            miniCorePkg::JR_TYPE: begin
                CntrlQ101H.RegWrEnable = 1'b1;
                CntrlQ101H.AluMux2Sel  = 1'b1; // rs1 + imm
                CntrlQ101H.JmpEnable   = 1'b1;
                CntrlQ101H.WbMuxSel    = `MINI_CORE_WB_PC4;
            end
            default: begin
                CntrlQ101H.Halt = 1'b1; // ECALL or illegal
            end
        endcase
    end

    // Held through EXECUTE, MEMORY and WRITEBACK
    always_ff @(posedge Clock) begin
        if (Reset) begin
            CntrlOut          <= '0;
            CntrlOut.WbMuxSel <= `MINI_CORE_WB_PC4;
        end else if (DecodeStrobe) begin
            CntrlOut <= CntrlQ101H;
        end
    end

    // A store never writes a register
    assert property (@(posedge Clock) disable iff (Reset)
        !(CntrlOut.MemWrEnable && CntrlOut.RegWrEnable))
        else $error("store with register write");

endmodule

// File: verilog/miniCoreDecoder.sv
`timescale 1ns/1ps

module miniCoreDecoder (
    input  miniCorePkg::tWord    Instr,
    output miniCorePkg::tDecoded Decoded
);

    logic [6:0]         Opcode;
    logic [2:0]         Funct3;
    logic [6:0]         Funct7;
    miniCorePkg::tWord  ImmI;
    miniCorePkg::tWord  ImmS;
    miniCorePkg::tWord  ImmB;
    miniCorePkg::tWord  ImmJ;
    miniCorePkg::tAluOp ArithOp; // Op for R and I arithmetic
    logic               ArithOk; // Funct fields name a supported op

    assign Opcode = Instr[6:0];
    assign Funct3 = Instr[14:12];
    assign Funct7 = Instr[31:25];

    assign ImmI = {{20{Instr[31]}}, Instr[31:20]};
    assign ImmS = {{20{Instr[31]}}, Instr[31:25], Instr[11:7]};
    assign ImmB = {{20{Instr[31]}}, Instr[7], Instr[30:25], Instr[11:8], 1'b0};
    assign ImmJ = {{12{Instr[31]}}, Instr[19:12], Instr[20], Instr[30:21], 1'b0};

    always_comb begin
        ArithOk = 1'b1;
        ArithOp = miniCorePkg::ALU_ADD;
        case (Funct3)
            3'b000: begin
                if (Opcode[5] && Funct7[5]) begin
                    ArithOp = miniCorePkg::ALU_SUB; // SUB only in R-type
                end
            end
            3'b010:  ArithOp = miniCorePkg::ALU_SLT;
            3'b100:  ArithOp = miniCorePkg::ALU_XOR;
            3'b110:  ArithOp = miniCorePkg::ALU_OR;
            3'b111:  ArithOp = miniCorePkg::ALU_AND;
            default: ArithOk = 1'b0; // Shifts and SLTU not supported
        endcase
        // R-type allows funct7 of zero, or 0100000 on SUB
        if (Opcode[5] && Funct7 != 7'b0 && !(Funct7 == 7'b0100000 && Funct3 == 3'b000)) begin
            ArithOk = 1'b0;
        end
    end

    always_comb begin
        Decoded.Rs1      = Instr[19:15];
        Decoded.Rs2      = Instr[24:20];
        Decoded.Rd       = Instr[11:7];
        Decoded.Imm      = ImmI;
        Decoded.OpType   = miniCorePkg::SYS_TYPE; // ECALL and anything unknown
        Decoded.AluOp    = miniCorePkg::ALU_ADD;  // Address math by default
        Decoded.BranchNe = 1'b0;
        case (Opcode)
            7'b0010011: begin
                if (ArithOk) begin
                    Decoded.OpType = miniCorePkg::I_TYPE;
                    Decoded.AluOp  = ArithOp;
                end
            end
            7'b0110011: begin
                if (ArithOk) begin
                    Decoded.OpType = miniCorePkg::R_TYPE;
                    Decoded.AluOp  = ArithOp;
                end
            end
            7'b0000011: begin
                if (Funct3 == 3'b010) begin
                    Decoded.OpType = miniCorePkg::L_TYPE; // LW only
                end
            end
            7'b0100011: begin
                if (Funct3 == 3'b010) begin
                    Decoded.OpType = miniCorePkg::S_TYPE; // SW only
                    Decoded.Imm    = ImmS;
                end
            end
            7'b1100011: begin
                if (Funct3[2:1] == 2'b00) begin
                    Decoded.OpType   = miniCorePkg::B_TYPE; // BEQ or BNE
                    Decoded.Imm      = ImmB;
                    Decoded.AluOp    = miniCorePkg::ALU_SUB;
                    Decoded.BranchNe = Funct3[0];
                end
            end
            7'b1101111: begin
                Decoded.OpType = miniCorePkg::J_TYPE;
                Decoded.Imm    = ImmJ;
            end
            7'b1100111: begin
                if (Funct3 == 3'b000) begin
                    Decoded.OpType = miniCorePkg::JR_TYPE;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/miniCorePkg.sv
`include "miniCore_params.svh"

package miniCorePkg;

    typedef logic [`MINI_CORE_XLEN-1:0]               tWord;   // Data, address, instruction
    typedef logic [$clog2(`MINI_CORE_REG_COUNT)-1:0] tRegIdx; // Register index
    typedef logic [1:0]                               tWbSel;  // Write-back source

    typedef enum logic [2:0] {
        I_TYPE,   // Register-immediate arithmetic
        L_TYPE,   // LW
        R_TYPE,   // Register-register arithmetic
        B_TYPE,   // BEQ, BNE
        S_TYPE,   // SW
        J_TYPE,   // JAL
        JR_TYPE,  // JALR
        SYS_TYPE  // ECALL and illegal encodings
    } tOpType;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } tAluOp;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } tSeqState;

    typedef struct packed {
        tRegIdx Rs1;
        tRegIdx Rs2;
        tRegIdx Rd;
        tWord   Imm;      // Sign-extended per format
        tOpType OpType;
        tAluOp  AluOp;
        logic   BranchNe; // Set for BNE
    } tDecoded;

    typedef struct packed {
        logic  RegWrEnable;
        logic  AluMux1Sel;  // Pc instead of rs1
        logic  AluMux2Sel;  // Immediate instead of rs2
        logic  MemWrEnable;
        logic  MemRdEnable;
        logic  JmpEnable;
        logic  IsBranch;
        tWbSel WbMuxSel;
        logic  Halt;
    } tControllerOut;

    typedef struct packed {
        logic Cyc;
        logic Stb;
        logic We;
        tWord Adr;
        tWord DatW;
    } tWbMaster;

endpackage

// File: verilog/miniCoreRegFile.sv
`timescale 1ns/1ps
`include "miniCore_params.svh"

module miniCoreRegFile (
    input  logic                Clock,
    input  logic                Reset,
    input  miniCorePkg::tRegIdx Rs1,
    input  miniCorePkg::tRegIdx Rs2,
    output miniCorePkg::tWord   Rs1Data,
    output miniCorePkg::tWord   Rs2Data,
    input  logic                WrEn,
    input  miniCorePkg::tRegIdx WrIdx,
    input  miniCorePkg::tWord   WrData
);

    miniCorePkg::tWord Regs [`MINI_CORE_REG_COUNT];

    always_ff @(posedge Clock) begin
        if (Reset) begin
            for (int i = 0; i < `MINI_CORE_REG_COUNT; i++) begin
                Regs[i] <= '0;
            end
        end else if (WrEn && WrIdx != '0) begin
            Regs[WrIdx] <= WrData; // x0 writes dropped
        end
    end

    assign Rs1Data = (Rs1 == '0) ? '0 : Regs[Rs1];
    assign Rs2Data = (Rs2 == '0) ? '0 : Regs[Rs2];

    // x0 stays zero across all writes
    assert property (@(posedge Clock) disable iff (Reset) Regs[0] == '0)
        else $error("x0 corrupted");

endmodule

// File: verilog/miniCoreSequencer.sv
`timescale 1ns/1ps
`include "miniCore_params.svh"

module miniCoreSequencer (
    input  logic                       Clock,
    input  logic                       Reset,
    input  miniCorePkg::tControllerOut Cntrl,
    input  miniCorePkg::tWord          AluResult,
    input  logic                       Taken,
    input  miniCorePkg::tWord          Rs2Data,
    output miniCorePkg::tWord          Instr,
    output miniCorePkg::tWord          Pc,
    output logic                       DecodeStrobe,
    output logic                       RegWrEn,
    output miniCorePkg::tWord          RegWrData,
    output miniCorePkg::tWbMaster      WbOut,
    input  logic                       WbAck,
    input  miniCorePkg::tWord          WbDatR,
    output logic                       Halted
);

    miniCorePkg::tSeqState State;
    miniCorePkg::tWord     AluQ;    // Result latched in EXECUTE
    miniCorePkg::tWord     LoadQ;   // LW data
    miniCorePkg::tWord     PcPlus4;
    logic                  TakenQ;
    logic                  BusCyc;
    logic                  BusDone; // Ack on a live cycle
    logic                  IsMemOp;

    assign PcPlus4      = Pc + `MINI_CORE_XLEN'(4);
    assign BusDone      = BusCyc && WbAck;
    assign IsMemOp      = Cntrl.MemRdEnable || Cntrl.MemWrEnable;
    assign DecodeStrobe = (State == miniCorePkg::DECODE);
    assign Halted       = (State == miniCorePkg::HALT);

    always_ff @(posedge Clock) begin
        if (Reset) begin
            State  <= miniCorePkg::FETCH;
            Pc     <= `MINI_CORE_RESET_PC;
            BusCyc <= 1'b0;
            TakenQ <= 1'b0;
        end else begin
            case (State)
                miniCorePkg::FETCH, miniCorePkg::MEMORY: begin
                    BusCyc <= !BusDone; // Opens after reset, drops after Ack
                    if (BusDone && State == miniCorePkg::FETCH) begin
                        State <= miniCorePkg::DECODE;
                    end else if (BusDone) begin
                        State <= miniCorePkg::WRITEBACK;
                    end
                end
                miniCorePkg::DECODE: State <= miniCorePkg::EXECUTE;
                miniCorePkg::EXECUTE: begin
                    TakenQ <= Taken;
                    if (Cntrl.Halt) begin
                        State <= miniCorePkg::HALT;
                    end else if (IsMemOp) begin
                        State  <= miniCorePkg::MEMORY;
                        BusCyc <= 1'b1; // Data access starts at once
                    end else begin
                        State <= miniCorePkg::WRITEBACK;
                    end
                end
                miniCorePkg::WRITEBACK: begin
                    // Bit 0 cleared for JALR, other targets already even
                    Pc     <= TakenQ ? {AluQ[`MINI_CORE_XLEN-1:1], 1'b0} : PcPlus4;
                    BusCyc <= 1'b1; // Next fetch
                    State  <= miniCorePkg::FETCH;
                end
                default: State <= miniCorePkg::HALT; // Stuck until reset
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (State == miniCorePkg::FETCH && BusDone) begin
            Instr <= WbDatR;
        end
        if (State == miniCorePkg::MEMORY && BusDone) begin
            LoadQ <= WbDatR;
        end
        if (State == miniCorePkg::EXECUTE) begin
            AluQ <= AluResult;
        end
    end

    always_comb begin
        WbOut.Cyc  = BusCyc;
        WbOut.Stb  = BusCyc && (State == miniCorePkg::FETCH || State == miniCorePkg::MEMORY);
        WbOut.We   = BusCyc && State == miniCorePkg::MEMORY && Cntrl.MemWrEnable;
        WbOut.Adr  = (State == miniCorePkg::MEMORY) ? AluQ : Pc;
        WbOut.DatW = Rs2Data; // Instr is stable during MEMORY
    end

    assign RegWrEn = (State == miniCorePkg::WRITEBACK) && Cntrl.RegWrEnable;

    always_comb begin
        case (Cntrl.WbMuxSel)
            `MINI_CORE_WB_PC4: RegWrData = PcPlus4; // Link address
            `MINI_CORE_WB_MEM: RegWrData = LoadQ;
            default:           RegWrData = AluQ;
        endcase
    end

    assert property (@(posedge Clock) disable iff (Reset) WbOut.Stb |-> WbOut.Cyc)
        else $error("Stb without Cyc");

    // Halt is final, no bus traffic afterwards
    assert property (@(posedge Clock) disable iff (Reset)
        State == miniCorePkg::HALT |-> !WbOut.Cyc)
        else $error("bus cycle while halted");

endmodule

// File: verilog/miniCore_params.svh
`ifndef MINI_CORE_PARAMS_SVH
`define MINI_CORE_PARAMS_SVH

// Core geometry
`define MINI_CORE_XLEN      32            // Data and address width
`define MINI_CORE_REG_COUNT 32            // Architectural registers
`define MINI_CORE_RESET_PC  32'h0000_0000 // First fetch address

// Write-back source encodings
`define MINI_CORE_WB_ALU 2'b00 // ALU result
`define MINI_CORE_WB_PC4 2'b01 // Link value pc+4
`define MINI_CORE_WB_MEM 2'b10 // Load data

`endif
